// ==== common/nic_pkg.sv ====
// NIC control plane shared definitions
// MMIO address map, field widths, CSR structs and the write-data union

package nic_pkg;

    // ============================================================
    // Identity and base addresses
    // ============================================================
    localparam logic [7:0]   NIC_ID        = 8'h01;
    localparam logic [127:0] AFU_UUID      = 128'h5e9f_03c1_7a2b_4d86_b0e4_19c3_62fa_d871;
    localparam logic [15:0]  CSR_BASE      = 16'h0000;
    localparam logic [15:0]  AFU_ID_BASE   = 16'h0000;
    localparam logic [7:0]   NIC_MODE_WORD = 8'h13;

    // 64-bit registers sit on even 32-bit MMIO offsets
    localparam logic [15:0] ADDR_MEM_TX          = CSR_BASE + 16'd0;
    localparam logic [15:0] ADDR_MEM_RX          = CSR_BASE + 16'd2;
    localparam logic [15:0] ADDR_NIC_START       = CSR_BASE + 16'd4;
    localparam logic [15:0] ADDR_NUM_FLOWS       = CSR_BASE + 16'd6;
    localparam logic [15:0] ADDR_INIT            = CSR_BASE + 16'd8;
    localparam logic [15:0] ADDR_NIC_STATUS      = CSR_BASE + 16'd10;
    localparam logic [15:0] ADDR_CCIP_RPS        = CSR_BASE + 16'd12;
    localparam logic [15:0] ADDR_GET_PCK_CNT     = CSR_BASE + 16'd14;
    localparam logic [15:0] ADDR_PCK_CNT         = CSR_BASE + 16'd16;
    localparam logic [15:0] ADDR_NIC_MODE        = CSR_BASE + 16'd18;
    localparam logic [15:0] ADDR_RX_QUEUE_SIZE   = CSR_BASE + 16'd22;
    localparam logic [15:0] ADDR_TX_BATCH_SIZE   = CSR_BASE + 16'd24;
    localparam logic [15:0] ADDR_RX_BATCH_SIZE   = CSR_BASE + 16'd26;
    localparam logic [15:0] ADDR_POLLING_RATE    = CSR_BASE + 16'd28;
    localparam logic [15:0] ADDR_CONN_SETUP      = CSR_BASE + 16'd30;
    localparam logic [15:0] ADDR_CONN_STATUS     = CSR_BASE + 16'd32;
    localparam logic [15:0] ADDR_LB              = CSR_BASE + 16'd34;
    localparam logic [15:0] ADDR_PHY_NET_ADDR    = CSR_BASE + 16'd36;
    localparam logic [15:0] ADDR_IPV4_NET_ADDR   = CSR_BASE + 16'd38;
    localparam logic [15:0] ADDR_NET_DROP_CNT_RD = CSR_BASE + 16'd40;
    localparam logic [15:0] ADDR_NET_DROP_CNT    = CSR_BASE + 16'd42;
    localparam logic [15:0] ADDR_TX_QUEUE_SIZE   = CSR_BASE + 16'd44;

    // ============================================================
    // Field widths and counters
    // ============================================================
    localparam int LMAX_NUM_OF_FLOWS   = 3;
    localparam int LMAX_RX_QUEUE_SIZE  = 3;
    localparam int LMAX_TX_QUEUE_SIZE  = 8;
    localparam int LMAX_CCIP_BATCH     = 4;
    localparam int LMAX_CCIP_DMA_BATCH = 4;
    localparam int LMAX_POLLING_RATE   = 8;
    localparam int RPS_WINDOW_CYCLES   = 1000;

    localparam int NUM_COUNTERS = 5;
    localparam int CNT_RPC_IN   = 0;
    localparam int CNT_RPC_OUT  = 1;
    localparam int CNT_PDROP    = 2;
    localparam int CNT_NET_TX   = 3;
    localparam int CNT_NET_RX   = 4;

    // ============================================================
    // Types
    // ============================================================
    typedef struct packed {
        logic        rd_valid;
        logic        wr_valid;
        logic [15:0] address;
        logic [8:0]  tid;
        logic [63:0] data;
    } mmio_req_t;

    typedef struct packed {
        logic        valid;
        logic [8:0]  tid;
        logic [63:0] data;
    } mmio_rsp_t;

    // b0 is the lowest byte of the word
    typedef struct packed {
        logic [7:0] b5, b4, b3, b2, b1, b0;
    } phy_addr_t;

    typedef struct packed {
        logic [7:0] b3, b2, b1, b0;
    } ipv4_t;

    typedef struct packed {
        logic [15:0] rsvd;
        phy_addr_t   addr;
    } phy_wdata_t;

    typedef struct packed {
        logic [31:0] rsvd;
        ipv4_t       addr;
    } ipv4_wdata_t;

    typedef union packed {
        logic [63:0] raw;
        phy_wdata_t  phy;
        ipv4_wdata_t ip;
    } mmio_wdata_u;

    typedef struct packed {
        logic [41:0]                    mem_tx_addr;
        logic [41:0]                    mem_rx_addr;
        logic                           start;
        logic [LMAX_NUM_OF_FLOWS-1:0]   num_flows_m1;
        logic [LMAX_RX_QUEUE_SIZE-1:0]  rx_queue_size_m1;
        logic [LMAX_TX_QUEUE_SIZE:0]    tx_queue_size;
        logic [LMAX_CCIP_BATCH-1:0]     tx_batch_size;
        logic [LMAX_CCIP_DMA_BATCH-1:0] rx_batch_size;
        logic [LMAX_POLLING_RATE-1:0]   polling_rate;
        logic                           lb;
        phy_addr_t                      phy_addr;
        ipv4_t                          ipv4_addr;
    } nic_cfg_t;

    typedef struct packed {
        logic rpc_in;
        logic rpc_out;
        logic pdrop_tx_flows;
        logic net_tx;
        logic net_rx;
    } nic_events_t;

    typedef struct packed {
        logic ccip_initialized;
        logic rpc_initialized;
        logic err_rpc_rx_fifo;
        logic err_rpc_tx_fifo;
        logic err_ccip;
        logic err_rpc;
    } layer_state_t;

    typedef struct packed {
        logic [7:0] nic_id;
        logic       ready;
        logic       running;
        logic       error;
        logic       err_rpc_rx_fifo;
        logic       err_rpc_tx_fifo;
        logic       err_ccip;
        logic       err_rpc;
    } nic_status_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] conn_id;
        logic        error;
    } conn_status_t;

endpackage

// ==== src/nic_csr_write.sv ====
// NIC CSR write side
// Decodes MMIO writes into the configuration registers and
// raises the one-cycle init, connection-setup and drop-count strobes

`timescale 1ns/1ps

module nic_csr_write import nic_pkg::*; (
    input  logic        ccip_clk,
    input  logic        reset,
    input  mmio_req_t   mmio_req,
    output nic_cfg_t    nic_cfg,
    output logic        init_strobe,
    output logic        conn_setup_valid,
    output logic [63:0] conn_setup_frame,
    output logic        drop_cnt_req_valid,
    output logic [4:0]  drop_cnt_req_id,
    output logic [7:0]  cnt_select
);

    mmio_wdata_u wdata;

    assign wdata = mmio_req.data;

    always_ff @(posedge ccip_clk) begin
        // Strobes fall again unless this cycle writes them
        init_strobe        <= 1'b0;
        conn_setup_valid   <= 1'b0;
        drop_cnt_req_valid <= 1'b0;

        if (mmio_req.wr_valid) begin
            case (mmio_req.address)
                ADDR_MEM_TX:        nic_cfg.mem_tx_addr <= wdata.raw[41:0];
                ADDR_MEM_RX:        nic_cfg.mem_rx_addr <= wdata.raw[41:0];
                ADDR_NIC_START:     nic_cfg.start       <= wdata.raw[0];
                ADDR_INIT:          init_strobe         <= 1'b1;
                ADDR_GET_PCK_CNT:   cnt_select          <= wdata.raw[7:0];
                ADDR_LB:            nic_cfg.lb          <= wdata.raw[0];
                // Software writes counts, hardware keeps count minus one
                ADDR_NUM_FLOWS: begin
                    nic_cfg.num_flows_m1 <= wdata.raw[LMAX_NUM_OF_FLOWS-1:0] - 1'b1;
                end
                ADDR_RX_QUEUE_SIZE: begin
                    nic_cfg.rx_queue_size_m1 <= wdata.raw[LMAX_RX_QUEUE_SIZE-1:0] - 1'b1;
                end
                ADDR_TX_QUEUE_SIZE: begin
                    nic_cfg.tx_queue_size <= wdata.raw[LMAX_TX_QUEUE_SIZE:0];
                end
                ADDR_TX_BATCH_SIZE: begin
                    nic_cfg.tx_batch_size <= wdata.raw[LMAX_CCIP_BATCH-1:0];
                end
                ADDR_RX_BATCH_SIZE: begin
                    nic_cfg.rx_batch_size <= wdata.raw[LMAX_CCIP_DMA_BATCH-1:0];
                end
                ADDR_POLLING_RATE: begin
                    nic_cfg.polling_rate <= wdata.raw[LMAX_POLLING_RATE-1:0];
                end
                ADDR_CONN_SETUP: begin
                    conn_setup_frame <= wdata.raw;
                    conn_setup_valid <= 1'b1;
                end
                // Byte-wise network addresses through the union views
                ADDR_PHY_NET_ADDR:  nic_cfg.phy_addr  <= wdata.phy.addr;
                ADDR_IPV4_NET_ADDR: nic_cfg.ipv4_addr <= wdata.ip.addr;
                ADDR_NET_DROP_CNT_RD: begin
                    drop_cnt_req_id    <= wdata.raw[4:0];
                    drop_cnt_req_valid <= 1'b1;
                end
                default: begin
                end
            endcase
        end

        if (reset) begin
            nic_cfg.start      <= 1'b0;
            cnt_select         <= 8'd0;
            init_strobe        <= 1'b0;
            conn_setup_valid   <= 1'b0;
            drop_cnt_req_valid <= 1'b0;
        end
    end

endmodule

// ==== src/nic_csr_read.sv ====
// NIC CSR read side
// Answers every MMIO read one cycle later with the feature header,
// the AFU ID or a status word, and holds the clear-on-read
// connection status

`timescale 1ns/1ps

module nic_csr_read import nic_pkg::*; (
    input  logic         ccip_clk,
    input  logic         reset,
    input  mmio_req_t    mmio_req,
    input  nic_status_t  status,
    input  logic [31:0]  rps,
    input  logic [63:0]  cnt_value,
    input  conn_status_t conn_status,
    input  logic [63:0]  net_drop_cnt,
    output mmio_rsp_t    mmio_rsp
);

    conn_status_t conn_q;
    logic         conn_rd;
    logic [63:0]  rd_data;

    assign conn_rd = mmio_req.rd_valid && (mmio_req.address == ADDR_CONN_STATUS);

    // ============================================================
    // Read multiplexer
    // ============================================================
    // DFH reserved words at offsets 6 and 8 read zero like any unmapped offset
    always_comb begin
        rd_data = 64'd0;
        case (mmio_req.address)
            // Device feature header with a single AFU entry
            AFU_ID_BASE + 16'd0: begin
                rd_data[63:60] = 4'h1;
                rd_data[40]    = 1'b1;
            end
            AFU_ID_BASE + 16'd2: rd_data = AFU_UUID[63:0];
            AFU_ID_BASE + 16'd4: rd_data = AFU_UUID[127:64];
            ADDR_NIC_STATUS: rd_data[$bits(nic_status_t)-1:0] = status;
            ADDR_CCIP_RPS:   rd_data[31:0] = rps;
            ADDR_PCK_CNT:    rd_data = cnt_value;
            ADDR_NIC_MODE:   rd_data[7:0] = NIC_MODE_WORD;
            ADDR_CONN_STATUS: rd_data[$bits(conn_status_t)-1:0] = conn_q;
            ADDR_NET_DROP_CNT: rd_data = net_drop_cnt;
            default: rd_data = 64'd0;
        endcase
    end

    always_ff @(posedge ccip_clk) begin
        mmio_rsp.valid <= mmio_req.rd_valid;
        mmio_rsp.tid   <= mmio_req.tid;
        mmio_rsp.data  <= rd_data;

        if (reset) begin
            mmio_rsp.valid <= 1'b0;
        end
    end

    // ============================================================
    // Connection status capture
    // ============================================================
    // A new status in the read cycle survives the clear
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            conn_q <= '0;
        end else if (conn_status.valid) begin
            conn_q <= conn_status;
        end else if (conn_rd) begin
            conn_q <= '0;
        end
    end

endmodule

// ==== src/nic_status_monitor.sv ====
// NIC status and throughput monitor
// Registers readiness, running state and the error summary, and
// counts incoming requests over a fixed window

`timescale 1ns/1ps

module nic_status_monitor import nic_pkg::*; (
    input  logic         ccip_clk,
    input  logic         reset,
    input  layer_state_t layer_state,
    input  logic         rpc_in,
    input  logic         start,
    output nic_status_t  status,
    output logic [31:0]  rps
);

    logic        ready_d;
    logic        rpc_in_q;
    logic [31:0] window_cnt;
    logic [31:0] req_cnt;

    assign ready_d = layer_state.ccip_initialized & layer_state.rpc_initialized;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            status <= '0;
        end else begin
            status.nic_id          <= NIC_ID;
            status.ready           <= ready_d;
            status.running         <= ready_d & start;
            status.err_rpc_rx_fifo <= layer_state.err_rpc_rx_fifo;
            status.err_rpc_tx_fifo <= layer_state.err_rpc_tx_fifo;
            status.err_ccip        <= layer_state.err_ccip;
            status.err_rpc         <= layer_state.err_rpc;
            status.error           <= layer_state.err_rpc_rx_fifo |
                                      layer_state.err_rpc_tx_fifo |
                                      layer_state.err_ccip |
                                      layer_state.err_rpc;
        end
    end

    // ============================================================
    // Requests per window
    // ============================================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            rpc_in_q   <= 1'b0;
            window_cnt <= 32'd0;
            req_cnt    <= 32'd0;
            rps        <= 32'd0;
        end else begin
            rpc_in_q <= rpc_in;
            if (window_cnt == 32'(RPS_WINDOW_CYCLES)) begin
                // Publish and start a fresh window
                rps        <= req_cnt;
                req_cnt    <= 32'd0;
                window_cnt <= 32'd0;
            end else begin
                window_cnt <= window_cnt + 32'd1;
                if (rpc_in_q) begin
                    req_cnt <= req_cnt + 32'd1;
                end
            end
        end
    end

endmodule

// ==== src/nic_pkt_counters.sv ====
// NIC event counters
// Five 64-bit counters, one per datapath event, with one of them
// selected for MMIO readout by a software-written id

`timescale 1ns/1ps

module nic_pkt_counters import nic_pkg::*; (
    input  logic        ccip_clk,
    input  logic        reset,
    input  nic_events_t events,
    input  logic [7:0]  cnt_select,
    output logic [63:0] cnt_value
);

    logic [NUM_COUNTERS-1:0] event_vec;
    logic [63:0]             cnt_q [NUM_COUNTERS];

    // Event bits placed at their counter ids
    assign event_vec[CNT_RPC_IN]  = events.rpc_in;
    assign event_vec[CNT_RPC_OUT] = events.rpc_out;
    assign event_vec[CNT_PDROP]   = events.pdrop_tx_flows;
    assign event_vec[CNT_NET_TX]  = events.net_tx;
    assign event_vec[CNT_NET_RX]  = events.net_rx;

    // ============================================================
    // Counter bank
    // ============================================================
    always_ff @(posedge ccip_clk) begin
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            if (reset) begin
                cnt_q[i] <= 64'd0;
            end else if (event_vec[i]) begin
                cnt_q[i] <= cnt_q[i] + 64'd1;
            end
        end
    end

    // Readout of the current value, ids past the bank read zero
    always_comb begin
        cnt_value = 64'd0;
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            if (cnt_select == 8'(i)) begin
                cnt_value = cnt_q[i];
            end
        end
    end

endmodule

// ==== src/nic_control.sv ====
// NIC control plane top level
// Connects the MMIO CSR blocks, the status monitor and the event
// counters on the CCI-P clock

`timescale 1ns/1ps

module nic_control import nic_pkg::*; (
    input  logic         ccip_clk,
    input  logic         reset,
    input  mmio_req_t    mmio_req,
    output mmio_rsp_t    mmio_rsp,
    output nic_cfg_t     nic_cfg,
    output logic         init_strobe,
    output logic         conn_setup_valid,
    output logic [63:0]  conn_setup_frame,
    output logic         drop_cnt_req_valid,
    output logic [4:0]   drop_cnt_req_id,
    input  nic_events_t  events,
    input  layer_state_t layer_state,
    input  conn_status_t conn_status,
    input  logic [63:0]  net_drop_cnt
);

    logic [7:0]  cnt_select;
    logic [63:0] cnt_value;
    logic [31:0] rps;
    nic_status_t status;

    nic_csr_write u_csr_write (
        .ccip_clk           (ccip_clk),
        .reset              (reset),
        .mmio_req           (mmio_req),
        .nic_cfg            (nic_cfg),
        .init_strobe        (init_strobe),
        .conn_setup_valid   (conn_setup_valid),
        .conn_setup_frame   (conn_setup_frame),
        .drop_cnt_req_valid (drop_cnt_req_valid),
        .drop_cnt_req_id    (drop_cnt_req_id),
        .cnt_select         (cnt_select)
    );

    nic_csr_read u_csr_read (
        .ccip_clk     (ccip_clk),
        .reset        (reset),
        .mmio_req     (mmio_req),
        .status       (status),
        .rps          (rps),
        .cnt_value    (cnt_value),
        .conn_status  (conn_status),
        .net_drop_cnt (net_drop_cnt),
        .mmio_rsp     (mmio_rsp)
    );

    nic_status_monitor u_status (
        .ccip_clk    (ccip_clk),
        .reset       (reset),
        .layer_state (layer_state),
        .rpc_in      (events.rpc_in),
        .start       (nic_cfg.start),
        .status      (status),
        .rps         (rps)
    );

    nic_pkt_counters u_counters (
        .ccip_clk   (ccip_clk),
        .reset      (reset),
        .events     (events),
        .cnt_select (cnt_select),
        .cnt_value  (cnt_value)
    );

endmodule

// ==== dv/nic_control_tb.sv ====
// NIC control plane testbench
// Applies a table of MMIO reads, writes and input changes to the DUT,
// then checks the event counters and the requests-per-second meter

`timescale 1ns/1ps

module nic_control_tb import nic_pkg::*; ();

    localparam int OP_RD  = 0;
    localparam int OP_WR  = 1;
    localparam int OP_STB = 2;
    localparam int OP_LS  = 3;
    localparam int OP_CS  = 4;
    localparam int WAIT_LIMIT = 16;
    localparam int RPS_PULSES = 23;
    localparam logic [63:0] DROP_CNT = 64'hfeed_0000_cafe_1234;
    // Type 1 in bits 63:60, end of list in bit 40
    localparam logic [63:0] DFH_WORD = {4'h1, 19'd0, 1'b1, 40'd0};
    localparam logic [17:0] CONN_WORD = {1'b1, 16'hbeef, 1'b1};

    typedef struct {
        int          op;
        logic [15:0] addr;
        logic [63:0] wdata;
        logic [63:0] exp;
    } row_t;

    logic         ccip_clk;
    logic         reset;
    mmio_req_t    mmio_req;
    mmio_rsp_t    mmio_rsp;
    nic_cfg_t     nic_cfg;
    logic         init_strobe;
    logic         conn_setup_valid;
    logic [63:0]  conn_setup_frame;
    logic         drop_cnt_req_valid;
    logic [4:0]   drop_cnt_req_id;
    nic_events_t  events;
    layer_state_t layer_state;
    conn_status_t conn_status;
    logic [63:0]  net_drop_cnt;

    int          errors;
    int          timeouts;
    logic [15:0] lfsr;
    logic [8:0]  next_tid;
    row_t        rows [$];

    nic_control dut_i (
        .ccip_clk           (ccip_clk),
        .reset              (reset),
        .mmio_req           (mmio_req),
        .mmio_rsp           (mmio_rsp),
        .nic_cfg            (nic_cfg),
        .init_strobe        (init_strobe),
        .conn_setup_valid   (conn_setup_valid),
        .conn_setup_frame   (conn_setup_frame),
        .drop_cnt_req_valid (drop_cnt_req_valid),
        .drop_cnt_req_id    (drop_cnt_req_id),
        .events             (events),
        .layer_state        (layer_state),
        .conn_status        (conn_status),
        .net_drop_cnt       (net_drop_cnt)
    );

    initial begin
        ccip_clk = 1'b0;
        forever #20 ccip_clk = ~ccip_clk;
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s", what);
    endtask

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Status word as the status rules define it
    function automatic logic [63:0] status_word(input logic ready, input logic running,
                                                input logic [3:0] errs);
        return 64'({NIC_ID, ready, running, |errs, errs});
    endfunction

    function automatic logic [2:0] strobes();
        return {init_strobe, conn_setup_valid, drop_cnt_req_valid};
    endfunction

    // The nic_cfg field that a write address lands in
    function automatic logic [63:0] cfg_field(input logic [15:0] addr);
        case (addr)
            ADDR_MEM_TX:        return 64'(nic_cfg.mem_tx_addr);
            ADDR_MEM_RX:        return 64'(nic_cfg.mem_rx_addr);
            ADDR_NIC_START:     return 64'(nic_cfg.start);
            ADDR_NUM_FLOWS:     return 64'(nic_cfg.num_flows_m1);
            ADDR_RX_QUEUE_SIZE: return 64'(nic_cfg.rx_queue_size_m1);
            ADDR_TX_QUEUE_SIZE: return 64'(nic_cfg.tx_queue_size);
            ADDR_TX_BATCH_SIZE: return 64'(nic_cfg.tx_batch_size);
            ADDR_RX_BATCH_SIZE: return 64'(nic_cfg.rx_batch_size);
            ADDR_POLLING_RATE:  return 64'(nic_cfg.polling_rate);
            ADDR_LB:            return 64'(nic_cfg.lb);
            // Network addresses rebuilt from their named bytes, b0 lowest
            ADDR_PHY_NET_ADDR: begin
                return {16'd0, nic_cfg.phy_addr.b5, nic_cfg.phy_addr.b4,
                        nic_cfg.phy_addr.b3, nic_cfg.phy_addr.b2,
                        nic_cfg.phy_addr.b1, nic_cfg.phy_addr.b0};
            end
            ADDR_IPV4_NET_ADDR: begin
                return {32'd0, nic_cfg.ipv4_addr.b3, nic_cfg.ipv4_addr.b2,
                        nic_cfg.ipv4_addr.b1, nic_cfg.ipv4_addr.b0};
            end
            default:            return 64'd0;
        endcase
    endfunction

    // ============================================================
    // MMIO access
    // ============================================================
    task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
        int         cnt;
        logic [8:0] tid;
        tid = next_tid;
        next_tid = next_tid + 9'd37;
        @(posedge ccip_clk);
        mmio_req.rd_valid <= 1'b1;
        mmio_req.address  <= addr;
        mmio_req.tid      <= tid;
        @(posedge ccip_clk);
        mmio_req.rd_valid <= 1'b0;
        cnt = 0;
        @(negedge ccip_clk);
        while (!mmio_rsp.valid && cnt < WAIT_LIMIT) begin
            @(negedge ccip_clk);
            cnt++;
        end
        data = mmio_rsp.data;
        if (!mmio_rsp.valid) begin
            note_timeout("an MMIO read response");
        end else begin
            // Response must come in the cycle right after the request
            check_val("mmio_rsp extra delay", 64'(cnt), 64'd0);
            check_val("mmio_rsp.tid", 64'(mmio_rsp.tid), 64'(tid));
        end
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        @(posedge ccip_clk);
        mmio_req.wr_valid <= 1'b1;
        mmio_req.address  <= addr;
        mmio_req.data     <= data;
        @(posedge ccip_clk);
        mmio_req.wr_valid <= 1'b0;
        @(negedge ccip_clk);
    endtask

    task automatic expect_pulse(input logic [2:0] mask, input logic [63:0] wdata);
        int cnt;
        cnt = 0;
        while ((strobes() & mask) == 3'b000 && cnt < WAIT_LIMIT) begin
            @(negedge ccip_clk);
            cnt++;
        end
        if ((strobes() & mask) == 3'b000) begin
            note_timeout("a command strobe");
        end else begin
            check_val("strobe extra delay", 64'(cnt), 64'd0);
            check_val("strobes", 64'(strobes()), 64'(mask));
            if (mask[1]) check_val("conn_setup_frame", conn_setup_frame, wdata);
            if (mask[0]) check_val("drop_cnt_req_id", 64'(drop_cnt_req_id), 64'(wdata[4:0]));
            @(negedge ccip_clk);
            check_val("strobes one cycle later", 64'(strobes()), 64'd0);
        end
    endtask

    // ============================================================
    // Stimulus table
    // ============================================================
    task automatic add_row(input int op, input logic [15:0] addr,
                           input logic [63:0] wdata, input logic [63:0] exp);
        row_t r;
        r.op = op;
        r.addr = addr;
        r.wdata = wdata;
        r.exp = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Feature header, AFU ID, reserved and unmapped words
        add_row(OP_RD, AFU_ID_BASE, 64'd0, DFH_WORD);
        add_row(OP_RD, AFU_ID_BASE + 16'd2, 64'd0, AFU_UUID[63:0]);
        add_row(OP_RD, AFU_ID_BASE + 16'd4, 64'd0, AFU_UUID[127:64]);
        add_row(OP_RD, AFU_ID_BASE + 16'd6, 64'd0, 64'd0);
        add_row(OP_RD, AFU_ID_BASE + 16'd8, 64'd0, 64'd0);
        add_row(OP_RD, 16'd20, 64'd0, 64'd0);
        add_row(OP_RD, 16'h0100, 64'd0, 64'd0);
        add_row(OP_RD, ADDR_NIC_MODE, 64'd0, 64'(NIC_MODE_WORD));
        add_row(OP_RD, ADDR_NET_DROP_CNT, 64'd0, DROP_CNT);
        // Configuration writes, upper bits dropped
        add_row(OP_WR, ADDR_MEM_TX, 64'hffff_f3ab_cdef_0123, 64'h3ab_cdef_0123);
        add_row(OP_WR, ADDR_MEM_RX, 64'h0000_0000_0004_1000, 64'h0000_0000_0004_1000);
        add_row(OP_WR, ADDR_NUM_FLOWS, 64'd5, 64'd4);
        add_row(OP_WR, ADDR_NUM_FLOWS, 64'd0, 64'd7);
        add_row(OP_WR, ADDR_RX_QUEUE_SIZE, 64'd3, 64'd2);
        add_row(OP_WR, ADDR_TX_QUEUE_SIZE, 64'h3ff, 64'h1ff);
        add_row(OP_WR, ADDR_TX_BATCH_SIZE, 64'h1a, 64'ha);
        add_row(OP_WR, ADDR_RX_BATCH_SIZE, 64'h5, 64'h5);
        add_row(OP_WR, ADDR_POLLING_RATE, 64'h1c8, 64'hc8);
        add_row(OP_WR, ADDR_LB, 64'd1, 64'd1);
        add_row(OP_WR, ADDR_PHY_NET_ADDR, 64'hdead_a1b2_c3d4_e5f6, 64'h0000_a1b2_c3d4_e5f6);
        add_row(OP_WR, ADDR_IPV4_NET_ADDR, 64'h1234_5678_c0a8_0107, 64'hc0a8_0107);
        add_row(OP_WR, ADDR_NIC_START, 64'd1, 64'd1);
        // Command strobes, exp holds {init, conn_setup, drop_cnt}
        add_row(OP_STB, ADDR_INIT, 64'd0, 64'b100);
        add_row(OP_STB, ADDR_CONN_SETUP, 64'h0123_4567_89ab_cdef, 64'b010);
        add_row(OP_STB, ADDR_NET_DROP_CNT_RD, 64'h2b, 64'b001);
        // Status against layer_state, start is set here
        add_row(OP_LS, 16'd0, 64'b110000, 64'd0);
        add_row(OP_RD, ADDR_NIC_STATUS, 64'd0, status_word(1'b1, 1'b1, 4'b0000));
        add_row(OP_LS, 16'd0, 64'b100000, 64'd0);
        add_row(OP_RD, ADDR_NIC_STATUS, 64'd0, status_word(1'b0, 1'b0, 4'b0000));
        add_row(OP_LS, 16'd0, 64'b111000, 64'd0);
        add_row(OP_RD, ADDR_NIC_STATUS, 64'd0, status_word(1'b1, 1'b1, 4'b1000));
        add_row(OP_LS, 16'd0, 64'b000100, 64'd0);
        add_row(OP_RD, ADDR_NIC_STATUS, 64'd0, status_word(1'b0, 1'b0, 4'b0100));
        add_row(OP_LS, 16'd0, 64'b000010, 64'd0);
        add_row(OP_RD, ADDR_NIC_STATUS, 64'd0, status_word(1'b0, 1'b0, 4'b0010));
        add_row(OP_LS, 16'd0, 64'b110001, 64'd0);
        add_row(OP_RD, ADDR_NIC_STATUS, 64'd0, status_word(1'b1, 1'b1, 4'b0001));
        add_row(OP_WR, ADDR_NIC_START, 64'd0, 64'd0);
        add_row(OP_LS, 16'd0, 64'b110000, 64'd0);
        add_row(OP_RD, ADDR_NIC_STATUS, 64'd0, status_word(1'b1, 1'b0, 4'b0000));
        // Connection status is cleared by its read
        add_row(OP_CS, 16'd0, 64'(CONN_WORD), 64'd0);
        add_row(OP_RD, ADDR_CONN_STATUS, 64'd0, 64'(CONN_WORD));
        add_row(OP_RD, ADDR_CONN_STATUS, 64'd0, 64'd0);
    endtask

    task automatic run_row(input row_t r);
        logic [63:0] got;
        case (r.op)
            OP_RD: begin
                mmio_read(r.addr, got);
                check_val($sformatf("mmio_rsp.data @ 0x%h", r.addr), got, r.exp);
            end
            OP_WR: begin
                mmio_write(r.addr, r.wdata);
                check_val($sformatf("nic_cfg @ 0x%h", r.addr), cfg_field(r.addr), r.exp);
            end
            OP_STB: begin
                mmio_write(r.addr, r.wdata);
                expect_pulse(r.exp[2:0], r.wdata);
            end
            OP_LS: begin
                @(posedge ccip_clk);
                layer_state <= r.wdata[5:0];
            end
            default: begin
                @(posedge ccip_clk);
                conn_status <= r.wdata[17:0];
                @(posedge ccip_clk);
                conn_status <= '0;
            end
        endcase
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin : stimulus
        logic [63:0] got;
        int          n_evt [NUM_COUNTERS];
        int          polls;
        errors = 0;
        timeouts = 0;
        lfsr = 16'd1962;
        next_tid = 9'h005;
        reset = 1'b1;
        mmio_req = '0;
        events = '0;
        layer_state = '0;
        conn_status = '0;
        net_drop_cnt = DROP_CNT;
        build_table();
        repeat (10) @(posedge ccip_clk);
        reset <= 1'b0;

        // rpc_in pulses around the middle of the first meter window
        repeat (RPS_WINDOW_CYCLES / 2) @(posedge ccip_clk);
        for (int i = 0; i < RPS_PULSES; i++) begin
            @(posedge ccip_clk);
            events.rpc_in <= 1'b1;
            @(posedge ccip_clk);
            events.rpc_in <= 1'b0;
        end
        polls = 0;
        got = 64'd0;
        while (got == 64'd0 && polls < RPS_WINDOW_CYCLES) begin
            mmio_read(ADDR_CCIP_RPS, got);
            polls++;
        end
        if (got == 64'd0) note_timeout("the rps window to close");
        else check_val("mmio_rsp.data for rps", got, 64'(RPS_PULSES));

        foreach (rows[i]) run_row(rows[i]);

        // Random pulse counts, 1 to 16 per event
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            rand_bits(4, n_evt[i]);
            n_evt[i] = n_evt[i] + 1;
        end
        for (int c = 0; c < 16; c++) begin
            @(posedge ccip_clk);
            events.rpc_in         <= (c < n_evt[CNT_RPC_IN]);
            events.rpc_out        <= (c < n_evt[CNT_RPC_OUT]);
            events.pdrop_tx_flows <= (c < n_evt[CNT_PDROP]);
            events.net_tx         <= (c < n_evt[CNT_NET_TX]);
            events.net_rx         <= (c < n_evt[CNT_NET_RX]);
        end
        @(posedge ccip_clk);
        events <= '0;
        // The rpc_in counter also holds the meter pulses
        n_evt[CNT_RPC_IN] = n_evt[CNT_RPC_IN] + RPS_PULSES;
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            mmio_write(ADDR_GET_PCK_CNT, 64'(i));
            mmio_read(ADDR_PCK_CNT, got);
            check_val($sformatf("mmio_rsp.data for counter %0d", i), got, 64'(n_evt[i]));
        end
        mmio_write(ADDR_GET_PCK_CNT, 64'd7);
        mmio_read(ADDR_PCK_CNT, got);
        check_val("mmio_rsp.data for counter 7", got, 64'd0);

        $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
common/nic_pkg.sv
src/nic_csr_write.sv
src/nic_csr_read.sv
src/nic_status_monitor.sv
src/nic_pkt_counters.sv
src/nic_control.sv
dv/nic_control_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the NIC control testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module nic_control_tb -o nic_control_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/nic_control_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
